// File: source/gpu_macros.svh
`ifndef GPU_MACROS_SVH
`define GPU_MACROS_SVH

// Visible frame size in pixels
`define GPU_FRAME_W           640
`define GPU_FRAME_H           480

// Pixel position widths
`define GPU_X_W               10
`define GPU_Y_W               9

// Word address into SRAM, room for two full frames
`define GPU_SRAM_ADDR_W       20

// Word offset where frame 1 starts
`define GPU_FRAME_WORDS       (`GPU_FRAME_W * `GPU_FRAME_H)

// SRAM read pipeline depth and busy spacing
`define GPU_SRAM_RD_LAT       2
`define GPU_SRAM_BUSY_PERIOD  8

// Configuration register address width
`define GPU_CFG_ADDR_W        2

`endif

// File: source/gpu_pxl_pkg.sv
`default_nettype none

`include "gpu_macros.svh"

package gpu_pxl_pkg;

  // YCbCr pixel as stored in one SRAM word
  typedef struct packed {
    logic [7:0]             y;    // Luma
    logic [3:0]             cb;   // Blue difference
    logic [3:0]             cr;   // Red difference
  } pxl_ycbcr_t;

  // Pixel transfer from a source into the gateway
  // Valid is wr or rd, never both
  typedef struct packed {
    pxl_ycbcr_t             pxl;  // Write data, ignored on reads
    logic [`GPU_X_W-1:0]    posx;
    logic [`GPU_Y_W-1:0]    posy;
    logic                   wr;   // Pixel write
    logic                   rd;   // Pixel read
  } pxl_req_t;

  // Read data returned to the GPU core, tagged with its position
  typedef struct packed {
    pxl_ycbcr_t             pxl;
    logic [`GPU_X_W-1:0]    posx;
    logic [`GPU_Y_W-1:0]    posy;
  } pxl_rsp_t;

endpackage

`default_nettype wire

// File: source/gpu_mem_pkg.sv
`default_nettype none

`include "gpu_macros.svh"

package gpu_mem_pkg;

  import gpu_pxl_pkg::*;

  // Access from the gateway to the SRAM controller
  typedef struct packed {
    logic [`GPU_SRAM_ADDR_W-1:0]  addr;     // Linear word address incl. frame base
    pxl_ycbcr_t                   wr_data;
    logic                         wr_en;
    logic                         rd_en;
  } sram_req_t;

  // Read return from the SRAM controller
  typedef struct packed {
    logic                         rd_valid; // One pulse per accepted read
    pxl_ycbcr_t                   rd_data;
  } sram_rsp_t;

  // Configuration write, single cycle strobe
  typedef struct packed {
    logic                         strobe;
    logic [`GPU_CFG_ADDR_W-1:0]   addr;
    logic [7:0]                   data;
  } cfg_wr_t;

endpackage

`default_nettype wire

// File: source/gpu_fb_cfg.sv
`default_nettype none

`include "gpu_macros.svh"

module gpu_fb_cfg
  import gpu_mem_pkg::*;
(
  input  logic      cr_intf,
  input  logic      reset,
  input  cfg_wr_t   cfg_wr,
  output logic      fb_sel,   // 0 selects frame 0, 1 selects frame 1
  output logic      aa_en     // Anti-alias port enable
);

  // Register map
  localparam logic [`GPU_CFG_ADDR_W-1:0] ADDR_FB_SEL = `GPU_CFG_ADDR_W'(0);
  localparam logic [`GPU_CFG_ADDR_W-1:0] ADDR_AA_EN  = `GPU_CFG_ADDR_W'(1);

  // Strobe has no handshake, the write lands at the strobe edge
  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      fb_sel <= 1'b0;             // Frame 0 after reset
      aa_en  <= 1'b1;             // Anti-alias port open after reset
    end
    else if (cfg_wr.strobe)
    begin
      case (cfg_wr.addr)
        ADDR_FB_SEL:
        begin
          fb_sel <= cfg_wr.data[0];
        end
        ADDR_AA_EN:
        begin
          aa_en <= cfg_wr.data[0];
        end
        default:
        begin
          // Unmapped address, nothing changes
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/gpu_pxl_gw.sv
`default_nettype none

`include "gpu_macros.svh"

module gpu_pxl_gw
  import gpu_pxl_pkg::*;
  import gpu_mem_pkg::*;
(
  input  logic        cr_intf,
  input  logic        reset,
  input  pxl_req_t    core_req,     // GPU core, fixed priority
  input  pxl_req_t    aa_req,       // Anti-alias unit
  output logic        core_ready,
  output logic        aa_ready,
  input  logic        fb_sel,
  input  logic        aa_en,
  output sram_req_t   sram_req,
  input  logic        sram_ready,
  input  sram_rsp_t   sram_rsp,
  output pxl_rsp_t    rsp,          // Read data back to the core
  output logic        rsp_valid
);

  localparam int LAT = `GPU_SRAM_RD_LAT;

  logic                           core_vld;
  logic                           aa_vld;
  logic                           rd_acc;
  pxl_req_t                       sel_req;       // Request after arbitration
  logic [`GPU_SRAM_ADDR_W-7:0]    posy_ext;
  logic [`GPU_SRAM_ADDR_W-7:0]    posy_mul10;
  logic [`GPU_SRAM_ADDR_W-1:0]    line_addr;     // posy*640 + posx
  logic [`GPU_SRAM_ADDR_W-1:0]    frame_base;
  logic [LAT-2:0]                 pos_vld;       // Stage holds a live read
  logic [`GPU_X_W-1:0]            posx_pipe [LAT];
  logic [`GPU_Y_W-1:0]            posy_pipe [LAT];

  assign core_vld = core_req.wr | core_req.rd;
  assign aa_vld   = (aa_req.wr | aa_req.rd) & aa_en;   // Disabled port looks idle

  // Core wins whenever it has something, anti-alias only fills idle core cycles
  always_comb
  begin
    if (core_vld)
      sel_req = core_req;
    else if (aa_vld)
      sel_req = aa_req;
    else
      sel_req = '0;
  end

  assign core_ready = core_vld & sram_ready;
  assign aa_ready   = aa_en & ~core_vld & sram_ready;

  // posy*640 = (posy*8 + posy*2) << 6, no multiplier
  always_comb
  begin
    posy_ext   = (`GPU_SRAM_ADDR_W-6)'(sel_req.posy);
    posy_mul10 = (posy_ext << 3) + (posy_ext << 1);
    line_addr  = {posy_mul10, 6'd0} + `GPU_SRAM_ADDR_W'(sel_req.posx);
    frame_base = fb_sel ? `GPU_SRAM_ADDR_W'(`GPU_FRAME_WORDS) : '0;
  end

  assign sram_req.addr    = line_addr + frame_base;
  assign sram_req.wr_data = sel_req.pxl;
  assign sram_req.wr_en   = sel_req.wr;
  assign sram_req.rd_en   = sel_req.rd;

  assign rd_acc = sel_req.rd & sram_ready;           // Read taken by SRAM this edge

  // Stage valids, position moves on only behind a live read
  always_ff @(posedge cr_intf)
  begin
    if (reset)
      pos_vld <= '0;
    else
      pos_vld <= (LAT-1)'({pos_vld, rd_acc});
  end

  // Position pipeline, same depth as SRAM read latency
  always_ff @(posedge cr_intf)
  begin
    if (rd_acc)
    begin
      posx_pipe[0] <= sel_req.posx;
      posy_pipe[0] <= sel_req.posy;
    end
    for (int i = 1; i < LAT; i++)
    begin
      if (pos_vld[i-1])
      begin
        posx_pipe[i] <= posx_pipe[i-1];
        posy_pipe[i] <= posy_pipe[i-1];
      end
    end
  end

  assign rsp.pxl   = sram_rsp.rd_data;
  assign rsp.posx  = posx_pipe[LAT-1];                 // Lines up with rd_valid
  assign rsp.posy  = posy_pipe[LAT-1];
  assign rsp_valid = sram_rsp.rd_valid;

endmodule

`default_nettype wire

// File: source/gpu_sram_ctrl.sv
`default_nettype none

`include "gpu_macros.svh"

module gpu_sram_ctrl
  import gpu_pxl_pkg::*;
  import gpu_mem_pkg::*;
(
  input  logic        cr_intf,
  input  logic        reset,
  input  sram_req_t   sram_req,
  output logic        sram_ready,   // Low one cycle in every busy period
  output sram_rsp_t   sram_rsp
);

  localparam int MEM_WORDS = 2 * `GPU_FRAME_WORDS;              // Two frames
  localparam int LAT       = `GPU_SRAM_RD_LAT;
  localparam int BUSY_W    = $clog2(`GPU_SRAM_BUSY_PERIOD);
  localparam logic [BUSY_W-1:0] BUSY_LAST = BUSY_W'(`GPU_SRAM_BUSY_PERIOD - 1);

  pxl_ycbcr_t           mem [MEM_WORDS];
  logic [BUSY_W-1:0]    busy_cnt;
  logic                 wr_acc;
  logic                 rd_acc;
  logic [LAT-1:0]       rd_vld_pipe;
  pxl_ycbcr_t           rd_data_pipe [LAT];

  // Memory starts out cleared
  initial
  begin
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = '0;
  end

  // Busy counter, free running from reset release
  always_ff @(posedge cr_intf)
  begin
    if (reset)
      busy_cnt <= '0;
    else if (busy_cnt == BUSY_LAST)
      busy_cnt <= '0;
    else
      busy_cnt <= busy_cnt + 1'b1;
  end

  assign sram_ready = (busy_cnt != BUSY_LAST);
  assign wr_acc     = sram_req.wr_en & sram_ready;
  assign rd_acc     = sram_req.rd_en & sram_ready;

  always_ff @(posedge cr_intf)
  begin
    if (wr_acc)
      mem[sram_req.addr] <= sram_req.wr_data;   // Stored at the accepting edge
  end

  // Read valid pipeline
  always_ff @(posedge cr_intf)
  begin
    if (reset)
      rd_vld_pipe <= '0;
    else
      rd_vld_pipe <= LAT'({rd_vld_pipe, rd_acc});
  end

  // Read data pipeline, first stage is the array read
  always_ff @(posedge cr_intf)
  begin
    rd_data_pipe[0] <= mem[sram_req.addr];
    for (int i = 1; i < LAT; i++)
      rd_data_pipe[i] <= rd_data_pipe[i-1];
  end

  assign sram_rsp.rd_valid = rd_vld_pipe[LAT-1];
  assign sram_rsp.rd_data  = rd_data_pipe[LAT-1];

endmodule

`default_nettype wire

// File: source/gpu_pxl_top.sv
`default_nettype none

module gpu_pxl_top
  import gpu_pxl_pkg::*;
  import gpu_mem_pkg::*;
(
  input  logic        cr_intf,
  input  logic        reset,
  input  pxl_req_t    core_req,
  input  pxl_req_t    aa_req,
  output logic        core_ready,
  output logic        aa_ready,
  input  cfg_wr_t     cfg_wr,
  output pxl_rsp_t    rsp,
  output logic        rsp_valid
);

  logic         fb_sel;
  logic         aa_en;
  sram_req_t    sram_req;
  logic         sram_ready;
  sram_rsp_t    sram_rsp;

  // Steering registers
  gpu_fb_cfg u_fb_cfg (
    .cr_intf    (cr_intf),
    .reset      (reset),
    .cfg_wr     (cfg_wr),
    .fb_sel     (fb_sel),
    .aa_en      (aa_en)
  );

  // Arbitration and address generation
  gpu_pxl_gw u_pxl_gw (
    .cr_intf    (cr_intf),
    .reset      (reset),
    .core_req   (core_req),
    .aa_req     (aa_req),
    .core_ready (core_ready),
    .aa_ready   (aa_ready),
    .fb_sel     (fb_sel),
    .aa_en      (aa_en),
    .sram_req   (sram_req),
    .sram_ready (sram_ready),
    .sram_rsp   (sram_rsp),
    .rsp        (rsp),
    .rsp_valid  (rsp_valid)
  );

  gpu_sram_ctrl u_sram_ctrl (
    .cr_intf    (cr_intf),
    .reset      (reset),
    .sram_req   (sram_req),
    .sram_ready (sram_ready),
    .sram_rsp   (sram_rsp)
  );

endmodule

`default_nettype wire

// File: bench/gpu_pxl_asserts.sv
`default_nettype none

`include "gpu_macros.svh"

module gpu_pxl_asserts
  import gpu_pxl_pkg::*;
(
  input  logic      cr_intf,
  input  logic      reset,
  input  pxl_req_t  core_req,
  input  pxl_req_t  aa_req,
  input  logic      core_vld,
  input  logic      aa_vld,     // Already gated by aa_en
  input  logic      core_ready,
  input  logic      aa_ready,
  input  logic      rd_acc,
  input  logic      rsp_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // Core keeps the anti-alias port off the bus
  core_prio: assert property (@(posedge cr_intf) disable iff (reset)
    core_vld |-> !aa_ready)
    else $error("aa_ready high while the core request is valid");

  one_grant: assert property (@(posedge cr_intf) disable iff (reset)
    !(core_ready && aa_ready))
    else $error("core_ready and aa_ready high together");

  // Fixed read latency, both directions
  rd_to_rsp: assert property (@(posedge cr_intf) disable iff (reset)
    rd_acc |-> ##`GPU_SRAM_RD_LAT rsp_valid)
    else $error("No response two cycles after an accepted read");

  rsp_from_rd: assert property (@(posedge cr_intf) disable iff (reset)
    rsp_valid |-> $past(rd_acc, `GPU_SRAM_RD_LAT))
    else $error("Response without a read two cycles earlier");

  // Stalled request must not move
  core_hold: assert property (@(posedge cr_intf) disable iff (reset)
    core_vld && !core_ready |=> $stable(core_req))
    else $error("Core request changed while stalled");

  aa_hold: assert property (@(posedge cr_intf) disable iff (reset)
    aa_vld && !aa_ready |=> $stable(aa_req))
    else $error("Anti-alias request changed while stalled");

endmodule

bind gpu_pxl_gw gpu_pxl_asserts u_pxl_asserts (
  .cr_intf    (cr_intf),
  .reset      (reset),
  .core_req   (core_req),
  .aa_req     (aa_req),
  .core_vld   (core_vld),
  .aa_vld     (aa_vld),
  .core_ready (core_ready),
  .aa_ready   (aa_ready),
  .rd_acc     (rd_acc),
  .rsp_valid  (rsp_valid)
);

`default_nettype wire

// File: bench/gpu_pxl_tb.sv
`default_nettype none

`include "gpu_macros.svh"

module gpu_pxl_tb
  import gpu_pxl_pkg::*;
  import gpu_mem_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_WR_RD  = 16;   // Write then read positions
  localparam int N_PRIO   = 8;    // Core/anti-alias collisions
  localparam int N_BP     = 32;   // Back-pressure burst
  localparam int N_FRAME  = 4;
  localparam int N_AA_OFF = 4;
  localparam int N_BURST  = 8;
  localparam int TOTAL_REQS = 2*N_WR_RD + 4*N_PRIO + N_BP + 4*N_FRAME
                              + 2*N_AA_OFF + 2 + 2*N_BURST;
  localparam int TIMEOUT_CYCLES = 4*TOTAL_REQS + 200;

  logic         cr_intf;
  logic         reset;
  pxl_req_t     core_req;
  pxl_req_t     aa_req;
  logic         core_ready;
  logic         aa_ready;
  cfg_wr_t      cfg_wr;
  pxl_rsp_t     rsp;
  logic         rsp_valid;

  logic [31:0]  lfsr = 32'hb7d401e6;
  pxl_ycbcr_t   model_mem [int];      // Word address to pixel, absent means zero
  pxl_rsp_t     exp_q [$];            // Reads in flight, oldest first
  logic         exp_fb_sel;
  logic         exp_aa_en;
  int           cycle_cnt;
  int           err_cnt;              // Wrong values
  int           fail_cnt;             // Protocol and flow failures
  int           stall_cnt;            // Core cycles spent waiting
  int           core_acc_cyc;
  int           aa_acc_cyc;

  always #20 cr_intf = ~cr_intf;      // 40 ns period

  always @(posedge cr_intf)
    cycle_cnt <= cycle_cnt + 1;

  gpu_pxl_top DUT (
    .cr_intf    (cr_intf),
    .reset      (reset),
    .core_req   (core_req),
    .aa_req     (aa_req),
    .core_ready (core_ready),
    .aa_ready   (aa_ready),
    .cfg_wr     (cfg_wr),
    .rsp        (rsp),
    .rsp_valid  (rsp_valid)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};       // One step per bit
    end
    rand_bits = v;
  endfunction

  function automatic pxl_ycbcr_t rand_pxl();
    logic [31:0] v;
    v = rand_bits(16);
    rand_pxl = v[15:0];
  endfunction

  task automatic rand_pos(output logic [`GPU_X_W-1:0] x, output logic [`GPU_Y_W-1:0] y);
    logic [31:0] v;
    v = rand_bits(`GPU_X_W) % `GPU_FRAME_W;
    x = v[`GPU_X_W-1:0];
    v = rand_bits(`GPU_Y_W) % `GPU_FRAME_H;
    y = v[`GPU_Y_W-1:0];
  endtask

  function automatic pxl_req_t make_req(input logic wr, input logic [`GPU_X_W-1:0] x,
                                        input logic [`GPU_Y_W-1:0] y, input pxl_ycbcr_t p);
    make_req = '{pxl: p, posx: x, posy: y, wr: wr, rd: ~wr};
  endfunction

  // Linear word address of a pixel, frame 1 sits above frame 0
  function automatic int pix_addr(input logic [`GPU_X_W-1:0] x,
                                  input logic [`GPU_Y_W-1:0] y, input logic fb);
    pix_addr = int'(y) * `GPU_FRAME_W + int'(x) + (fb ? `GPU_FRAME_WORDS : 0);
  endfunction

  // Reference model update for one accepted request
  task automatic model_take(input pxl_req_t r);
    int       addr;
    pxl_rsp_t e;
    addr = pix_addr(r.posx, r.posy, exp_fb_sel);
    if (r.wr)
      model_mem[addr] = r.pxl;
    else if (r.rd)
    begin
      e.pxl  = model_mem.exists(addr) ? model_mem[addr] : '0;
      e.posx = r.posx;
      e.posy = r.posy;
      exp_q.push_back(e);
    end
  endtask

  // Mid-cycle sampling, all DUT outputs settled
  always @(negedge cr_intf)
  begin : monitor
    pxl_rsp_t front;
    logic     core_vld;
    logic     aa_vld;
    core_vld = core_req.wr | core_req.rd;
    aa_vld   = aa_req.wr | aa_req.rd;
    if (!reset)
    begin
      if (rsp_valid)
      begin
        assert (exp_q.size() > 0)
        else
        begin
          fail_cnt++;
          $display("t=%0t response arrived with no read outstanding", $time);
        end
        if (exp_q.size() > 0)
        begin
          front = exp_q.pop_front();
          assert (rsp == front)
          else
          begin
            err_cnt++;
            $display("[ERROR] t=%0t rsp expected %h got %h", $time, front, rsp);
          end
        end
      end
      assert (!(core_ready && aa_ready))
      else
      begin
        fail_cnt++;
        $display("t=%0t both ports granted in one cycle", $time);
      end
      assert (!(core_vld && aa_ready))
      else
      begin
        fail_cnt++;
        $display("t=%0t anti-alias port ready while the core is requesting", $time);
      end
      assert (exp_aa_en || !aa_ready)
      else
      begin
        fail_cnt++;
        $display("t=%0t anti-alias port ready while disabled", $time);
      end
      if (core_vld && !core_ready)
        stall_cnt++;
      if (core_vld && core_ready)
      begin
        core_acc_cyc = cycle_cnt;
        model_take(core_req);
      end
      else if (aa_vld && aa_ready && exp_aa_en)
      begin
        aa_acc_cyc = cycle_cnt;
        model_take(aa_req);
      end
    end
  end

  // Holds a core request until the handshake completes
  task automatic core_send(input pxl_req_t r);
    logic took;
    core_req = r;
    took = 1'b0;
    while (!took)
    begin
      @(negedge cr_intf);
      took = core_ready;
      @(posedge cr_intf);
      #2;
    end
    core_req = '0;
  endtask

  // Anti-alias request, withdrawn after limit cycles
  task automatic aa_send(input pxl_req_t r, input int limit, output logic took);
    int n;
    aa_req = r;
    took = 1'b0;
    n = 0;
    while (!took && n < limit)
    begin
      @(negedge cr_intf);
      took = aa_ready;
      @(posedge cr_intf);
      #2;
      n++;
    end
    aa_req = '0;
  endtask

  task automatic cfg_write(input logic [`GPU_CFG_ADDR_W-1:0] a, input logic [7:0] d);
    cfg_wr = '{strobe: 1'b1, addr: a, data: d};
    @(posedge cr_intf);
    #2;
    cfg_wr = '0;
    if (a == 0)
      exp_fb_sel = d[0];
    else if (a == 1)
      exp_aa_en = d[0];
  endtask

  // Waits for outstanding reads to return
  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 10)
    begin
      @(posedge cr_intf);
      #2;
      n++;
    end
    assert (exp_q.size() == 0)
    else
    begin
      fail_cnt++;
      $display("t=%0t %0d read responses never arrived", $time, exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic write_then_read();
    logic [`GPU_X_W-1:0] xs [N_WR_RD];
    logic [`GPU_Y_W-1:0] ys [N_WR_RD];
    for (int i = 0; i < N_WR_RD; i++)
    begin
      rand_pos(xs[i], ys[i]);
      core_send(make_req(1'b1, xs[i], ys[i], rand_pxl()));
    end
    for (int i = 0; i < N_WR_RD; i++)
      core_send(make_req(1'b0, xs[i], ys[i], '0));
    drain();
  endtask

  task automatic priority_clash();
    logic [`GPU_X_W-1:0] xa, xc;
    logic [`GPU_Y_W-1:0] ya, yc;
    pxl_ycbcr_t          pa, pc;
    logic                took;
    for (int i = 0; i < N_PRIO; i++)
    begin
      rand_pos(xa, ya);
      rand_pos(xc, yc);
      pa = rand_pxl();
      pc = rand_pxl();
      fork
        core_send(make_req(1'b1, xc, yc, pc));
        aa_send(make_req(1'b1, xa, ya, pa), 20, took);
      join
      assert (took && aa_acc_cyc > core_acc_cyc)
      else
      begin
        fail_cnt++;
        $display("t=%0t anti-alias write not served after the core write", $time);
      end
      core_send(make_req(1'b0, xa, ya, '0));
      core_send(make_req(1'b0, xc, yc, '0));
    end
    drain();
  endtask

  // Small position window so reads hit earlier writes
  task automatic stall_burst();
    logic [31:0] v;
    int          stalls_before;
    logic        wr;
    stalls_before = stall_cnt;
    for (int i = 0; i < N_BP; i++)
    begin
      v = rand_bits(1);
      wr = v[0];
      v = rand_bits(4);
      core_send(make_req(wr, `GPU_X_W'(v[1:0]), `GPU_Y_W'(v[3:2]), rand_pxl()));
    end
    drain();
    assert (stall_cnt > stalls_before)
    else
    begin
      fail_cnt++;
      $display("t=%0t burst never met a busy SRAM cycle", $time);
    end
  endtask

  task automatic frame_switch();
    logic [`GPU_X_W-1:0] x;
    logic [`GPU_Y_W-1:0] y;
    pxl_ycbcr_t          p0;
    for (int i = 0; i < N_FRAME; i++)
    begin
      rand_pos(x, y);
      p0 = rand_pxl();
      core_send(make_req(1'b1, x, y, p0));
      cfg_write(0, 8'd1);
      core_send(make_req(1'b1, x, y, ~p0));   // Differs from frame 0
      core_send(make_req(1'b0, x, y, '0));
      cfg_write(0, 8'd0);
      core_send(make_req(1'b0, x, y, '0));
    end
    drain();
  endtask

  task automatic aa_gating();
    logic [`GPU_X_W-1:0] x;
    logic [`GPU_Y_W-1:0] y;
    logic                took;
    cfg_write(1, 8'd0);
    for (int i = 0; i < N_AA_OFF; i++)
    begin
      rand_pos(x, y);
      aa_send(make_req(1'b1, x, y, rand_pxl()), 12, took);
      assert (!took)
      else
      begin
        fail_cnt++;
        $display("t=%0t anti-alias write accepted while disabled", $time);
      end
      core_send(make_req(1'b0, x, y, '0));
    end
    cfg_write(1, 8'd1);
    rand_pos(x, y);
    aa_send(make_req(1'b1, x, y, rand_pxl()), 20, took);
    assert (took)
    else
    begin
      fail_cnt++;
      $display("t=%0t anti-alias write not accepted after re-enable", $time);
    end
    core_send(make_req(1'b0, x, y, '0));
    drain();
  endtask

  // Reads on consecutive cycles, two in flight
  task automatic back_to_back_reads();
    logic [31:0]         v;
    logic [`GPU_X_W-1:0] x0;
    logic [`GPU_Y_W-1:0] y0;
    v = rand_bits(9);
    x0 = `GPU_X_W'(v[8:0]);                // Leaves room for the run
    v = rand_bits(`GPU_Y_W) % `GPU_FRAME_H;
    y0 = v[`GPU_Y_W-1:0];
    for (int i = 0; i < N_BURST; i++)
      core_send(make_req(1'b1, x0 + `GPU_X_W'(i), y0, rand_pxl()));
    for (int i = N_BURST - 1; i >= 0; i--)
      core_send(make_req(1'b0, x0 + `GPU_X_W'(i), y0, '0));
    drain();
  endtask

  initial
  begin : main
    cr_intf = 1'b0;
    reset = 1'b1;
    core_req = '0;
    aa_req = '0;
    cfg_wr = '0;
    exp_fb_sel = 1'b0;
    exp_aa_en = 1'b1;
    cycle_cnt = 0;
    err_cnt = 0;
    fail_cnt = 0;
    stall_cnt = 0;
    core_acc_cyc = 0;
    aa_acc_cyc = 0;
    repeat (4) @(posedge cr_intf);
    #2;
    reset = 1'b0;
    write_then_read();
    priority_clash();
    stall_burst();
    frame_switch();
    aa_gating();
    back_to_back_reads();
    $display("Summary: %0d value errors, %0d other errors", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin : watchdog
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
    $display("Summary: %0d value errors, %0d other errors", err_cnt, fail_cnt);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/gpu_pxl_pkg.sv
source/gpu_mem_pkg.sv
source/gpu_fb_cfg.sv
source/gpu_pxl_gw.sv
source/gpu_sram_ctrl.sv
source/gpu_pxl_top.sv
bench/gpu_pxl_asserts.sv
bench/gpu_pxl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the pixel gateway testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module gpu_pxl_tb -f src.f -o gpu_pxl_sim

./obj_dir/gpu_pxl_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
